// ==== Makefile ====
sim:
	verilator --binary --timing --assert -j 0 --top-module exUnitTb -f exUnit.f -o exUnitSim
	./obj_dir/exUnitSim

clean:
	rm -rf obj_dir

// ==== bench/exModel.svh ====
// Reference model of the execute stage: flag state and expected result of one instruction
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

// Model flags, carry per thread
logic [NUM_THREADS-1:0] mCarry;
logic                   mIe, mBip, mBe;

// Updates the model flags and returns the expected result word
function automatic logic [DATA_W-1:0] exRef(input instWord inst,
                                           input logic [DATA_W-1:0] a,
                                           input logic [DATA_W-1:0] b,
                                           input logic [DATA_W-1:0] pc,
                                           input logic [THR_W-1:0] thr);
   logic [5:0]        opc;
   logic [5:0]        grp;   // Opcode without the immediate bit
   logic              c;
   logic              nc;
   logic [DATA_W:0]   wide;
   logic [DATA_W-1:0] r;
   opc = inst.typeA.opc;
   grp = opc & 6'b110111;
   c   = mCarry[thr];
   r   = pc;   // Link value for brk and return ops
   if (opc == OPC_RTD) begin
      if (inst.typeA.rd == RD_RTID)
         mIe = 1'b1;
      if (inst.typeA.rd == RD_RTBD)
         mBip = 1'b0;
   end else if (grp[5:4] == 2'b00) begin
      if (opc[0]) begin   // Reverse subtract, B minus A
         wide = {1'b0, b} - {1'b0, a} - {{DATA_W{1'b0}}, opc[1] & ~c};
         nc   = ~wide[DATA_W];   // No borrow means carry set
      end else begin
         wide = {1'b0, b} + {1'b0, a} + {{DATA_W{1'b0}}, opc[1] & c};
         nc   = wide[DATA_W];
      end
      r = wide[DATA_W-1:0];
      if (opc == OPC_CMP && inst.typeA.alt[0])   // cmpu when alt bit 1 set
         r[DATA_W-1] = inst.typeA.alt[1] ? (a > b) : ($signed(a) > $signed(b));
      if (!opc[2])
         mCarry[thr] = nc;   // Keep forms leave carry alone
   end else if (grp[5:2] == 4'b1000) begin
      case (opc[1:0])
         2'd0:    r = a | b;
         2'd1:    r = a & b;
         2'd2:    r = a ^ b;
         default: r = a & ~b;
      endcase
   end else if (grp == OPC_SFT) begin
      case (inst.typeB.imm[6:5])
         2'd0:    r = {a[DATA_W-1], a[DATA_W-1:1]};
         2'd1:    r = {c, a[DATA_W-1:1]};   // Through carry
         2'd2:    r = {1'b0, a[DATA_W-1:1]};
         default: r = inst.typeB.imm[0] ? {{16{a[15]}}, a[15:0]} : {{24{a[7]}}, a[7:0]};
      endcase
      if (inst.typeB.imm[6:5] != 2'd3)
         mCarry[thr] = a[0];   // Bit shifted out
   end else if (opc == OPC_MSR) begin
      if (inst.typeB.imm[MTS_BIT]) begin
         r           = a;
         mCarry[thr] = a[MSR_C];
         mIe         = a[MSR_IE];
         mBip        = a[MSR_BIP];
         mBe         = a[MSR_BE];
      end else if (inst.typeB.imm[0]) begin
         r = '0;
         r[MSR_VER_LSB +: 16] = MSR_VER;
         r[MSR_BE]  = mBe;
         r[MSR_IE]  = mIe;
         r[MSR_C]   = c;   // Reading thread's carry
         r[MSR_BIP] = mBip;
      end
   end else if (grp == OPC_BRK) begin
      mBip = 1'b1;
      if (inst.typeA.ra == RA_INT)
         mIe = 1'b0;
   end else if (grp == OPC_MUL) begin
      r = a * b;   // Low word only
   end else if (grp == OPC_BSF) begin
      case (inst.typeA.alt[10:9])
         2'd1:    r = $signed(a) >>> b[4:0];
         2'd2:    r = a << b[4:0];
         default: r = a >> b[4:0];
      endcase
   end
   return r;
endfunction

`endif

// ==== bench/exUnitTb.sv ====
// Testbench for the execute stage: credit driven stimulus, reference check and watchdog
`timescale 1ns/100ps

module exUnitTb;
   import exPkg::*;

   localparam int N_ADD      = 64;
   localparam int N_LOG      = 64;
   localparam int N_BSF      = 48;
   localparam int N_MSR      = 32;
   localparam int N_SLOW     = 40;
   localparam int N_ALL      = N_ADD + N_LOG + N_BSF + N_MSR + N_SLOW;
   localparam int SLOW_FROM  = N_ALL - N_SLOW;   // Credits come back slowly from here
   localparam int RST_CYCLES = 2;
   localparam int DRAIN      = 200;
   localparam int WATCHDOG   = RST_CYCLES + 20 * N_ALL + DRAIN + 10;

   logic              clk, rst;
   logic              issValid, issCredit, resValid, resCredit;
   instWord           issInst;
   logic [DATA_W-1:0] issOpA, issOpB, issPc, resData;
   logic [THR_W-1:0]  issThread, resThread;
   logic [4:0]        resRd;

   integer            seed;
   int                sentCnt, creditPulses, resultsSeen, creditsBack;
   int                retDelay [N_ALL];   // Consumer delay per returned credit
   logic [DATA_W-1:0] expData [$];
   logic [4:0]        expRd [$];
   logic [THR_W-1:0]  expThr [$];

   `include "exModel.svh"

   exUnit exUnit_inst (
      .clk_i       (clk),
      .rst_i       (rst),
      .issValid_i  (issValid),
      .issInst_i   (issInst),
      .issOpA_i    (issOpA),
      .issOpB_i    (issOpB),
      .issPc_i     (issPc),
      .issThread_i (issThread),
      .issCredit_o (issCredit),
      .resValid_o  (resValid),
      .resData_o   (resData),
      .resRd_o     (resRd),
      .resThread_o (resThread),
      .resCredit_i (resCredit)
   );

   initial begin : clockGen
      clk = 1'b0;
      forever #2 clk = ~clk;   // 4 ns period
   end

   task automatic stopRun();
      $display("Test FAILED");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic reportValue(input string sig, input logic [DATA_W-1:0] expV,
                              input logic [DATA_W-1:0] gotV);
      $display("[FAIL] %s expected %h got %h", sig, expV, gotV);
      stopRun();
   endtask

   task automatic reportText(input string what);
      $display("%s", what);
      stopRun();
   endtask

   function automatic logic [31:0] nextRand();
      return $random(seed);
   endfunction

   function automatic instWord makeRegInst(input logic [5:0] opc, input logic [4:0] rd,
                                           input logic [4:0] ra, input logic [10:0] alt);
      instWord w;
      w.typeA.opc = opc;
      w.typeA.rd  = rd;
      w.typeA.ra  = ra;
      w.typeA.rb  = 5'd3;
      w.typeA.alt = alt;
      return w;
   endfunction

   function automatic instWord makeImmInst(input logic [5:0] opc, input logic [4:0] rd,
                                           input logic [4:0] ra, input logic [15:0] imm);
      instWord w;
      w.typeB.opc = opc;
      w.typeB.rd  = rd;
      w.typeB.ra  = ra;
      w.typeB.imm = imm;
      return w;
   endfunction

   // Waits for an issue credit, drives one instruction for a cycle
   task automatic sendInst(input instWord inst, input logic [DATA_W-1:0] a,
                           input logic [DATA_W-1:0] b, input logic [THR_W-1:0] thr);
      logic [DATA_W-1:0] pc;
      pc = DATA_W'(32'h1000 + sentCnt * 4);
      while (ISS_DEPTH - sentCnt + creditPulses <= 0) begin
         issValid = 1'b0;
         @(posedge clk);
         #1;
      end
      issValid  = 1'b1;
      issInst   = inst;
      issOpA    = a;
      issOpB    = b;
      issPc     = pc;
      issThread = thr;
      sentCnt++;
      expData.push_back(exRef(inst, a, b, pc, thr));   // Model runs in issue order
      expRd.push_back(inst.typeA.rd);
      expThr.push_back(thr);
      @(posedge clk);
      #1;
      issValid = 1'b0;
   endtask

   // Kind 0 add group, 1 logic and shifts, 2 barrel shift and multiply
   task automatic sendRandom(input int kind);
      logic [31:0] r, a, b;
      logic [5:0]  opc;
      logic [4:0]  rd;
      logic [1:0]  k;
      instWord     w;
      r   = nextRand();
      a   = nextRand();
      b   = nextRand();
      rd  = r[20:16];
      opc = {3'b000, r[2:0]};
      k   = (r[1:0] == 2'd3) ? 2'd0 : r[1:0];
      case (kind)
         0: begin
            if (r[5:4] == 2'b00)
               b = a ^ {30'b0, r[7:6]};   // Equal or close operands
            if (r[9:8] == 2'b00) begin
               w = makeRegInst(OPC_CMP, rd, 5'd1, {9'b0, r[10], 1'b1});
            end else if (r[3]) begin
               w = makeImmInst(opc | 6'b001000, rd, 5'd1, b[15:0]);
               b = {{16{b[15]}}, b[15:0]};
            end else begin
               w = makeRegInst(opc, rd, 5'd1, 11'd0);
            end
         end
         1: begin
            if (r[3])
               w = makeRegInst(OPC_LOG | {4'b0, r[1:0]}, rd, 5'd1, 11'd0);
            else if (r[2])
               w = makeRegInst({4'b0000, 1'b1, r[0]}, rd, 5'd1, 11'd0);   // addc or rsubc
            else
               w = makeRegInst(OPC_SFT, rd, 5'd1,
                               {4'b0, r[1:0], 4'b0, (r[1:0] == 2'd3) ? r[4] : 1'b1});
         end
         default: begin
            if (r[3]) begin
               w = makeRegInst(OPC_MUL, rd, 5'd1, 11'd0);
            end else if (r[4]) begin
               w = makeImmInst(OPC_BSF | 6'b001000, rd, 5'd1, {5'b0, k, 4'b0, b[4:0]});
               b = {27'b0, b[4:0]};
            end else begin
               w = makeRegInst(OPC_BSF, rd, 5'd1, {k, 9'b0});
            end
         end
      endcase
      sendInst(w, a, b, THR_W'(r[31]));
   endtask

   // Fixed MSR sequence with random data and thread
   task automatic sendMsrStep(input int step);
      logic [31:0] r, a;
      logic [4:0]  rd;
      instWord     w;
      r  = nextRand();
      a  = nextRand();
      rd = r[20:16];
      case (step % 8)
         0:       w = makeImmInst(OPC_MSR, 5'd0, 5'd1, 16'hC001);   // mts
         1:       w = makeImmInst(OPC_MSR, rd, 5'd0, r[5] ? 16'h8000 : 16'h8001);
         2:       w = makeRegInst(OPC_BRK, rd, RA_BRK, 11'd0);
         4:       w = makeImmInst(OPC_RTD, RD_RTBD, 5'd15, 16'h0008);
         5:       w = makeImmInst(OPC_BRK | 6'b001000, rd, RA_INT, 16'h0010);
         6:       w = makeImmInst(OPC_RTD, RD_RTID, 5'd14, 16'h0000);
         default: w = makeImmInst(OPC_MSR, rd, 5'd0, 16'h8001);   // mfs msr
      endcase
      sendInst(w, a, 32'd0, THR_W'(r[31]));
   endtask

   initial begin : mainSeq
      logic [31:0] r;
      seed      = 29677;
      rst       = 1'b1;
      issValid  = 1'b0;
      issInst   = '0;
      issOpA    = '0;
      issOpB    = '0;
      issPc     = '0;
      issThread = '0;
      sentCnt   = 0;
      mCarry    = '0;
      mIe       = 1'b0;
      mBip      = 1'b0;
      mBe       = 1'b0;
      for (int i = 0; i < N_ALL; i++) begin
         r = nextRand();
         retDelay[i] = (i >= SLOW_FROM) ? 8 + int'(r[2:0]) : int'(r[1:0]);
      end
      repeat (RST_CYCLES) @(posedge clk);
      #1;
      rst = 1'b0;
      for (int i = 0; i < N_ADD; i++)
         sendRandom(0);
      for (int i = 0; i < N_LOG; i++)
         sendRandom(1);
      for (int i = 0; i < N_BSF; i++)
         sendRandom(2);
      for (int i = 0; i < N_MSR; i++)
         sendMsrStep(i);
      for (int i = 0; i < N_SLOW; i++)
         sendRandom(i % 3);   // Mixed ops under slow credit return
      for (int i = 0; i < DRAIN && expData.size() != 0; i++)
         @(posedge clk);
      assert (creditPulses == sentCnt)
         else reportValue("issCredit_o pulse count", DATA_W'(sentCnt), DATA_W'(creditPulses));
      if (expData.size() == 0) begin
         $display("Test OK");
         $finish;
      end else begin
         reportText("Results still missing after the drain period");
      end
   end

   // Outputs sampled mid-cycle
   initial begin : checkOut
      logic [DATA_W-1:0] eData;
      logic [4:0]        eRd;
      logic [THR_W-1:0]  eThr;
      resultsSeen  = 0;
      creditPulses = 0;
      forever begin
         @(negedge clk);
         if (!rst && issCredit) begin
            creditPulses++;
            assert (creditPulses <= sentCnt)
               else reportText("issCredit_o pulsed without an accepted instruction");
         end
         if (!rst && resValid) begin
            assert (expData.size() != 0)
               else reportText("A result appeared with no instruction outstanding");
            eData = expData.pop_front();
            eRd   = expRd.pop_front();
            eThr  = expThr.pop_front();
            resultsSeen++;
            assert (resultsSeen - creditsBack <= RES_CREDITS)
               else reportText("More results outstanding than result credits");
            assert (resData == eData) else reportValue("resData_o", eData, resData);
            assert (resRd == eRd) else reportValue("resRd_o", DATA_W'(eRd), DATA_W'(resRd));
            assert (resThread == eThr)
               else reportValue("resThread_o", DATA_W'(eThr), DATA_W'(resThread));
         end
      end
   end

   // Consumer hands back one credit per result after its delay
   initial begin : creditReturn
      int waitCnt;
      resCredit   = 1'b0;
      creditsBack = 0;
      waitCnt     = 0;
      forever begin
         @(posedge clk);
         #1;
         resCredit = 1'b0;
         if (resultsSeen > creditsBack) begin
            if (waitCnt >= retDelay[creditsBack]) begin
               resCredit = 1'b1;
               creditsBack++;
               waitCnt = 0;
            end else begin
               waitCnt++;
            end
         end
      end
   end

   initial begin : watchdog
      repeat (WATCHDOG) @(posedge clk);
      reportText("Timeout: the run did not finish within the allowed number of cycles");
   end

endmodule

// ==== common/exBus.sv ====
// Issued operation bus from the control block to the execute units
`timescale 1ns/100ps

interface exBus;
   import exPkg::*;

   logic                valid;   // Issue this cycle
   logic [THR_W-1:0]    thread;
   instWord             inst;    // Carries opcode and imm/alt field
   unitSel              unitSrc; // Decoded result source
   logic [DATA_W-1:0]   opA;     // ra or pc
   logic [DATA_W-1:0]   opB;     // rb or imm
   logic [DATA_W-1:0]   pc;

   modport master (
      output valid, thread, inst, unitSrc, opA, opB, pc
   );

   modport unit (
      input valid, thread, inst, unitSrc, opA, opB, pc
   );

endinterface

// ==== common/exPkg.sv ====
// Execute stage shared constants, opcode groups, unit codes and instruction formats
package exPkg;

   // Widths and depths
   localparam int DATA_W      = 32;
   localparam int ISS_DEPTH   = 2;   // Input buffer entries, also upstream credits
   localparam int RES_CREDITS = 4;   // Result credits held after reset
   localparam int NUM_THREADS = 2;
   localparam int THR_W       = $clog2(NUM_THREADS);
   localparam int PTR_W       = $clog2(ISS_DEPTH);
   localparam int CNT_W       = $clog2(ISS_DEPTH + 1);
   localparam int CRD_W       = $clog2(RES_CREDITS + 1);

   // Result source
   typedef enum logic [2:0] {
      UNIT_ADD = 3'd0,
      UNIT_LOG = 3'd1,
      UNIT_SFT = 3'd2,
      UNIT_MOV = 3'd3,
      UNIT_MUL = 3'd4,
      UNIT_BSF = 3'd5
   } unitSel;

   // Major opcodes, register form (bit 3 clear)
   localparam logic [5:0] OPC_ADD = 6'b000000;  // Group base, opc[5:4] == 0
   localparam logic [5:0] OPC_CMP = 6'b000101;  // rsubk slot, alt[0] marks cmp
   localparam logic [5:0] OPC_LOG = 6'b100000;  // or/and/xor/andn in opc[1:0]
   localparam logic [5:0] OPC_SFT = 6'b100100;
   localparam logic [5:0] OPC_MSR = 6'b100101;  // mfs/mts, imm[14] set for mts
   localparam logic [5:0] OPC_BRK = 6'b100110;
   localparam logic [5:0] OPC_RTD = 6'b101101;  // rtsd family, subop in rd
   localparam logic [5:0] OPC_MUL = 6'b010000;
   localparam logic [5:0] OPC_BSF = 6'b010001;
   localparam int         OPC_IMM_BIT = 3;      // Immediate form marker

   // Sub-decode fields
   localparam logic [4:0] RA_BRK  = 5'h0C;  // Plain break
   localparam logic [4:0] RA_INT  = 5'h0E;  // Interrupt-type break
   localparam logic [4:0] RD_RTID = 5'h11;
   localparam logic [4:0] RD_RTBD = 5'h12;
   localparam int         MTS_BIT = 14;

   // Register form
   typedef struct packed {
      logic [5:0]  opc;
      logic [4:0]  rd;
      logic [4:0]  ra;
      logic [4:0]  rb;
      logic [10:0] alt;
   } typeA_t;

   // Immediate form
   typedef struct packed {
      logic [5:0]  opc;
      logic [4:0]  rd;
      logic [4:0]  ra;
      logic [15:0] imm;
   } typeB_t;

   typedef union packed {
      typeA_t typeA;
      typeB_t typeB;
   } instWord;

   // MSR layout
   localparam int MSR_BE  = 0;
   localparam int MSR_IE  = 1;
   localparam int MSR_C   = 2;
   localparam int MSR_BIP = 3;
   localparam int MSR_VER_LSB = 16;
   localparam logic [15:0] MSR_VER = 16'h5A32;  // Vendor and version, read only

endpackage

// ==== exUnit.f ====
+incdir+bench
common/exPkg.sv
common/exBus.sv
execute/exCtrl.sv
execute/intAlu.sv
execute/barrelShift.sv
execute/mulPipe.sv
execute/statusReg.sv
rtl/exUnit.sv
bench/exUnitTb.sv

// ==== execute/barrelShift.sv ====
// Combinational barrel shifter: logical right, arithmetic right and left
`timescale 1ns/100ps

module barrelShift (
   exBus.unit                          bus,
   output logic [exPkg::DATA_W-1:0]    res_o
);
   import exPkg::*;

   logic [4:0]        shAmt;
   logic [1:0]        kind;
   logic [DATA_W-1:0] srl, sra, sll;

   assign shAmt = bus.opB[4:0];
   assign kind  = bus.inst.typeA.alt[10:9];

   assign srl = bus.opA >> shAmt;
   assign sra = DATA_W'($signed(bus.opA) >>> shAmt);  // Sign fills from the top
   assign sll = bus.opA << shAmt;

   always_comb begin
      case (kind)
         2'd1:    res_o = sra;
         2'd2:    res_o = sll;
         default: res_o = srl;  // Kind 3 unused, treated as logical right
      endcase
   end

endmodule

// ==== execute/exCtrl.sv ====
// Execute control with input buffer, issue and result credits, decode and result pipeline
`timescale 1ns/100ps

module exCtrl (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        issValid_i,
   input  exPkg::instWord              issInst_i,
   input  logic [exPkg::DATA_W-1:0]    issOpA_i,
   input  logic [exPkg::DATA_W-1:0]    issOpB_i,
   input  logic [exPkg::DATA_W-1:0]    issPc_i,
   input  logic [exPkg::THR_W-1:0]     issThread_i,
   output logic                        issCredit_o,
   input  logic                        resCredit_i,
   exBus.master                        bus,
   input  logic [exPkg::DATA_W-1:0]    aluRes_i,
   input  logic [exPkg::DATA_W-1:0]    bsfRes_i,
   input  logic [exPkg::DATA_W-1:0]    mulRes_i,
   output logic                        resValid_o,
   output logic [exPkg::DATA_W-1:0]    resData_o,
   output logic [4:0]                  resRd_o,
   output logic [exPkg::THR_W-1:0]     resThread_o
);
   import exPkg::*;

   // Buffered payload per entry
   instWord           instBuf [ISS_DEPTH];
   logic [DATA_W-1:0] opABuf  [ISS_DEPTH];
   logic [DATA_W-1:0] opBBuf  [ISS_DEPTH];
   logic [DATA_W-1:0] pcBuf   [ISS_DEPTH];
   logic [THR_W-1:0]  thrBuf  [ISS_DEPTH];

   logic [PTR_W-1:0] wrPtr, rdPtr;
   logic [CNT_W-1:0] count;
   logic [CRD_W-1:0] resCrd;  // Result credits in hand
   logic             pop;

   // Stage registers
   logic              s1Valid, s2Valid;
   logic [4:0]        s1Rd, s2Rd;
   logic [THR_W-1:0]  s1Thread, s2Thread;
   unitSel            s1Unit, s2Unit;
   logic [DATA_W-1:0] s1Data, s2Data;

   // Opcode to result source
   function automatic unitSel decodeUnit(input logic [5:0] opc);
      logic [5:0] base;
      base = opc;
      base[OPC_IMM_BIT] = 1'b0;
      if (opc == OPC_RTD)  // Checked first since rtd aliases mfs without the imm bit
         return UNIT_MOV;
      else if (base[5:4] == OPC_ADD[5:4])
         return UNIT_ADD;
      else if (base[5:2] == OPC_LOG[5:2])
         return UNIT_LOG;
      else if (base == OPC_SFT)
         return UNIT_SFT;
      else if (base == OPC_MUL)
         return UNIT_MUL;
      else if (base == OPC_BSF)
         return UNIT_BSF;
      else
         return UNIT_MOV;  // mfs/mts/brk
   endfunction

   assign pop = (count != '0) && (resCrd != '0);  // Head issues with a credit

   // Issue onto the unit bus
   assign bus.valid   = pop;
   assign bus.inst    = instBuf[rdPtr];
   assign bus.thread  = thrBuf[rdPtr];
   assign bus.opA     = opABuf[rdPtr];
   assign bus.opB     = opBBuf[rdPtr];
   assign bus.pc      = pcBuf[rdPtr];
   assign bus.unitSrc = decodeUnit(instBuf[rdPtr].typeA.opc);

   always_ff @(posedge clk_i) begin
      if (issValid_i) begin  // Upstream never overruns its credits
         instBuf[wrPtr] <= issInst_i;
         opABuf[wrPtr]  <= issOpA_i;
         opBBuf[wrPtr]  <= issOpB_i;
         pcBuf[wrPtr]   <= issPc_i;
         thrBuf[wrPtr]  <= issThread_i;
      end
   end

   // Pointers, counters and valids
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wrPtr       <= '0;
         rdPtr       <= '0;
         count       <= '0;
         resCrd      <= CRD_W'(RES_CREDITS);
         issCredit_o <= 1'b0;
         s1Valid     <= 1'b0;
         s2Valid     <= 1'b0;
      end else begin
         if (issValid_i)
            wrPtr <= wrPtr + 1'b1;
         if (pop)
            rdPtr <= rdPtr + 1'b1;
         count       <= count + CNT_W'(issValid_i) - CNT_W'(pop);
         resCrd      <= resCrd - CRD_W'(pop) + CRD_W'(resCredit_i);
         issCredit_o <= pop;  // One credit back per entry leaving
         s1Valid     <= pop;
         s2Valid     <= s1Valid;
      end
   end

   // Result payload through stage 1 and stage 2
   always_ff @(posedge clk_i) begin
      s1Rd     <= bus.inst.typeA.rd;
      s1Thread <= bus.thread;
      s1Unit   <= bus.unitSrc;
      s1Data   <= (bus.unitSrc == UNIT_BSF) ? bsfRes_i : aluRes_i;
      s2Rd     <= s1Rd;
      s2Thread <= s1Thread;
      s2Unit   <= s1Unit;
      s2Data   <= s1Data;
   end

   assign resValid_o  = s2Valid;
   assign resRd_o     = s2Rd;
   assign resThread_o = s2Thread;
   assign resData_o   = (s2Unit == UNIT_MUL) ? mulRes_i : s2Data;  // Product lands at stage 2

endmodule

// ==== execute/intAlu.sv ====
// Integer ALU for add/sub/compare, logic, one-bit shift, sign extend and moves with carry out
`timescale 1ns/100ps

module intAlu (
   exBus.unit                          bus,
   input  logic                        carry_i,
   input  logic [exPkg::DATA_W-1:0]    msr_i,
   output logic [exPkg::DATA_W-1:0]    res_o,
   output logic                        carry_o
);
   import exPkg::*;

   logic [5:0]        opc;
   logic [10:0]       alt;
   logic [15:0]       imm;
   logic [DATA_W-1:0] opA, opB;

   logic [DATA_W-1:0] opX;  // A or ~A for reverse subtract
   logic              cin;
   logic [DATA_W-1:0] addSum, addRes;
   logic              addC, addCo;
   logic              isCmp, gt;
   logic [DATA_W-1:0] logRes;
   logic [DATA_W-1:0] sftRes;
   logic              sftC;
   logic [DATA_W-1:0] movRes;

   assign opc = bus.inst.typeA.opc;
   assign alt = bus.inst.typeA.alt;  // Register form subop
   assign imm = bus.inst.typeB.imm;  // Immediate form subop
   assign opA = bus.opA;
   assign opB = bus.opB;

   // Adder with subtract in opc[0], carry in in opc[1] and keep carry in opc[2]
   assign opX = opc[0] ? ~opA : opA;
   assign cin = opc[1] ? carry_i : opc[0];
   assign {addC, addSum} = {1'b0, opB} + {1'b0, opX} + {{DATA_W{1'b0}}, cin};

   assign isCmp = (opc == OPC_CMP) && alt[0];
   assign gt    = alt[1] ? (opA > opB) : ($signed(opA) > $signed(opB));  // cmpu / cmp
   assign addRes = isCmp ? {gt, addSum[DATA_W-2:0]} : addSum;
   assign addCo  = opc[2] ? carry_i : addC;  // Carry is inverted borrow on sub

   always_comb begin
      case (opc[1:0])
         2'd0:    logRes = opA | opB;
         2'd1:    logRes = opA & opB;
         2'd2:    logRes = opA ^ opB;
         default: logRes = opA & ~opB;  // andn
      endcase
   end

   // One-bit right shifts and sign extension
   always_comb begin
      sftC = opA[0];
      case (imm[6:5])
         2'd0: sftRes = {opA[DATA_W-1], opA[DATA_W-1:1]};  // sra
         2'd1: sftRes = {carry_i, opA[DATA_W-1:1]};        // src
         2'd2: sftRes = {1'b0, opA[DATA_W-1:1]};           // srl
         default: begin
            sftC   = carry_i;  // sext leaves carry
            sftRes = imm[0] ? {{16{opA[15]}}, opA[15:0]} : {{24{opA[7]}}, opA[7:0]};
         end
      endcase
   end

   // mfs reads MSR or pc while mts passes opA and brk/rtd link the pc
   always_comb begin
      if (opc == OPC_MSR)
         movRes = imm[MTS_BIT] ? opA : (imm[0] ? msr_i : bus.pc);
      else
         movRes = bus.pc;
   end

   always_comb begin
      case (bus.unitSrc)
         UNIT_ADD: res_o = addRes;
         UNIT_LOG: res_o = logRes;
         UNIT_SFT: res_o = sftRes;
         UNIT_MOV: res_o = movRes;
         default:  res_o = '0;  // Mul and bsf come from their own units
      endcase
   end

   always_comb begin
      case (bus.unitSrc)
         UNIT_ADD: carry_o = addCo;
         UNIT_SFT: carry_o = sftC;
         default:  carry_o = carry_i;
      endcase
   end

endmodule

// ==== execute/mulPipe.sv ====
// Two-stage multiplier returning the low product word
`timescale 1ns/100ps

module mulPipe (
   input  logic                        clk_i,
   exBus.unit                          bus,
   output logic [exPkg::DATA_W-1:0]    res_o
);
   import exPkg::*;

   logic [DATA_W-1:0] prodS1;  // Stage 1 product

   // Runs every cycle so it stays aligned with the result pipe
   always_ff @(posedge clk_i) begin
      prodS1 <= DATA_W'(bus.opA * bus.opB);
      res_o  <= prodS1;  // Stage 2
   end

endmodule

// ==== execute/statusReg.sv ====
// Machine status: per-thread carry, shared IE/BIP/BE and MSR read value
`timescale 1ns/100ps

module statusReg (
   input  logic                        clk_i,
   input  logic                        rst_i,
   exBus.unit                          bus,
   input  logic                        newCarry_i,
   output logic                        carry_o,
   output logic [exPkg::DATA_W-1:0]    msr_o
);
   import exPkg::*;

   logic [NUM_THREADS-1:0] carry;  // One per thread
   logic                   ie, bip, be;
   logic [5:0]             opc;
   logic [5:0]             opcBase;
   logic                   isMts, isBrk, isInt, isRtid, isRtbd;

   assign opc     = bus.inst.typeA.opc;
   assign opcBase = {opc[5:4], 1'b0, opc[2:0]};  // Drop immediate bit

   assign isMts  = bus.valid && (opc == OPC_MSR) && bus.inst.typeB.imm[MTS_BIT];
   assign isInt  = bus.valid && (opcBase == OPC_BRK) && (bus.inst.typeA.ra == RA_INT);
   assign isBrk  = bus.valid && (opcBase == OPC_BRK)
                   && ((bus.inst.typeA.ra == RA_BRK) || (bus.inst.typeA.ra == RA_INT));
   assign isRtid = bus.valid && (opc == OPC_RTD) && (bus.inst.typeA.rd == RD_RTID);
   assign isRtbd = bus.valid && (opc == OPC_RTD) && (bus.inst.typeA.rd == RD_RTBD);

   assign carry_o = carry[bus.thread];  // Issuing thread

   // Flags move at the issue edge
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         carry <= '0;
         ie    <= 1'b0;
         bip   <= 1'b0;
         be    <= 1'b0;
      end else begin
         if (bus.valid)
            carry[bus.thread] <= isMts ? bus.opA[MSR_C] : newCarry_i;  // ALU returns old C if unused
         if (isInt)
            ie <= 1'b0;
         else if (isRtid)
            ie <= 1'b1;
         else if (isMts)
            ie <= bus.opA[MSR_IE];
         if (isBrk)
            bip <= 1'b1;
         else if (isRtbd)
            bip <= 1'b0;
         else if (isMts)
            bip <= bus.opA[MSR_BIP];
         if (isMts)
            be <= bus.opA[MSR_BE];
      end
   end

   // MSR view for mfs
   always_comb begin
      msr_o = '0;
      msr_o[MSR_VER_LSB +: 16] = MSR_VER;
      msr_o[MSR_BE]  = be;
      msr_o[MSR_IE]  = ie;
      msr_o[MSR_C]   = carry_o;
      msr_o[MSR_BIP] = bip;
   end

endmodule

// ==== rtl/exUnit.sv ====
// Execute stage top level with credit-based issue and result ports
`timescale 1ns/100ps

module exUnit (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        issValid_i,
   input  exPkg::instWord              issInst_i,
   input  logic [exPkg::DATA_W-1:0]    issOpA_i,
   input  logic [exPkg::DATA_W-1:0]    issOpB_i,
   input  logic [exPkg::DATA_W-1:0]    issPc_i,
   input  logic [exPkg::THR_W-1:0]     issThread_i,
   output logic                        issCredit_o,
   output logic                        resValid_o,
   output logic [exPkg::DATA_W-1:0]    resData_o,
   output logic [4:0]                  resRd_o,
   output logic [exPkg::THR_W-1:0]     resThread_o,
   input  logic                        resCredit_i
);
   import exPkg::*;

   exBus bus ();  // Issued operation

   logic [DATA_W-1:0] aluRes, bsfRes, mulRes;
   logic [DATA_W-1:0] msr;
   logic              carry, newCarry;

   exCtrl uCtrl (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .issValid_i  (issValid_i),
      .issInst_i   (issInst_i),
      .issOpA_i    (issOpA_i),
      .issOpB_i    (issOpB_i),
      .issPc_i     (issPc_i),
      .issThread_i (issThread_i),
      .issCredit_o (issCredit_o),
      .resCredit_i (resCredit_i),
      .bus         (bus.master),
      .aluRes_i    (aluRes),
      .bsfRes_i    (bsfRes),
      .mulRes_i    (mulRes),
      .resValid_o  (resValid_o),
      .resData_o   (resData_o),
      .resRd_o     (resRd_o),
      .resThread_o (resThread_o)
   );

   intAlu uAlu (.bus(bus.unit), .carry_i(carry), .msr_i(msr), .res_o(aluRes), .carry_o(newCarry));

   barrelShift uBsf (.bus(bus.unit), .res_o(bsfRes));

   mulPipe uMul (.clk_i(clk_i), .bus(bus.unit), .res_o(mulRes));

   statusReg uMsr (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .bus        (bus.unit),
      .newCarry_i (newCarry),
      .carry_o    (carry),
      .msr_o      (msr)
   );

endmodule
